/* logic/drac_pkg.sv */
// widths, register map and status layout shared by the motor-channel logic
// address bits 7:4 pick the channel and bits 3:0 the offset; bits 15:8 are don't-care
// channel 0 is the board, channels 1..NUM_MOTORS are motor channels
package drac_pkg;

    localparam int NUM_MOTORS       = 4;
    localparam int NUM_SAMPLE_QUADS = NUM_MOTORS + 2;   // timestamp, status, setpoints

    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [3:0]  chan_t;
    typedef logic [3:0]  ofs_t;          // register offset within a channel
    typedef logic [5:0]  sample_addr_t;
    typedef logic [31:0] timestamp_t;
    typedef logic [15:0] setpoint_t;     // low half of a quadlet
    typedef logic [NUM_MOTORS-1:0] amp_mask_t;
    typedef logic [$clog2(NUM_MOTORS)-1:0] motor_idx_t;
    typedef logic [$clog2(NUM_MOTORS+1)-1:0] quad_idx_t;      // 0..NUM_MOTORS
    typedef logic [$clog2(NUM_SAMPLE_QUADS)-1:0] sample_idx_t;

    localparam chan_t BOARD_CHAN      = 4'd0;
    localparam ofs_t  OFS_STATUS      = 4'd0;   // board, read only
    localparam ofs_t  OFS_WDOG_PERIOD = 4'd3;   // board
    localparam ofs_t  OFS_SETPOINT    = 4'd0;   // motor
    localparam ofs_t  OFS_AMP_EN      = 4'd1;   // motor, bit 0

    localparam int STAT_TIMEOUT_BIT = 8;
    localparam int STAT_AMP_LSB     = 16;

    typedef enum logic [1:0] {HOST, BLOCK, DRAIN} arb_state_e;
    typedef enum logic {IDLE, ACTIVE} bw_state_e;

    function automatic chan_t addr_chan(input reg_addr_t addr);
        return addr[7:4];
    endfunction

    function automatic ofs_t addr_ofs(input reg_addr_t addr);
        return addr[3:0];
    endfunction

    function automatic reg_addr_t make_addr(input chan_t ch, input ofs_t ofs);
        return {8'h00, ch, ofs};
    endfunction

    // board status quadlet, also copied into the sample buffer
    function automatic reg_data_t status_word(input chan_t id, input logic timeout,
                                              input amp_mask_t amp_en);
        reg_data_t w;
        w = '0;
        w[3:0] = id;
        w[STAT_TIMEOUT_BIT] = timeout;
        w[STAT_AMP_LSB +: NUM_MOTORS] = amp_en;
        return w;
    endfunction

endpackage

/* logic/write_bus_arbiter.sv */
`timescale 1ns/1ps
// one registered write bus; the block writer owns it whenever bw_write_en is high
// a single host write can wait out a block and is replayed right after it
// host writes arriving while that slot is full are lost
module write_bus_arbiter (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                reg_wen,
    input  drac_pkg::reg_addr_t reg_waddr,
    input  drac_pkg::reg_data_t reg_wdata,
    input  logic                bw_write_en,
    input  logic                bw_reg_wen,
    input  drac_pkg::reg_addr_t bw_reg_waddr,
    input  drac_pkg::reg_data_t bw_reg_wdata,
    output logic                bus_wen,
    output drac_pkg::reg_addr_t bus_waddr,
    output drac_pkg::reg_data_t bus_wdata
);

    drac_pkg::arb_state_e arb_state;
    logic                 pend_valid;     // host write parked during a block
    drac_pkg::reg_addr_t  pend_waddr;
    drac_pkg::reg_data_t  pend_wdata;
    logic                 pend_load;

    // park a host write while the block writer holds the bus
    assign pend_load = reg_wen && !pend_valid &&
                       (bw_write_en || arb_state == drac_pkg::BLOCK);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            arb_state  <= drac_pkg::HOST;
            bus_wen    <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            bus_wen <= 1'b0;
            if (bw_write_en) begin
                arb_state <= drac_pkg::BLOCK;
                bus_wen   <= bw_reg_wen;     // block writer straight through
                bus_waddr <= bw_reg_waddr;
                bus_wdata <= bw_reg_wdata;
            end else begin
                case (arb_state)
                    drac_pkg::BLOCK: arb_state <= drac_pkg::DRAIN;   // block just ended
                    drac_pkg::DRAIN: begin
                        bus_wen    <= pend_valid;   // replay the parked write
                        bus_waddr  <= pend_waddr;
                        bus_wdata  <= pend_wdata;
                        pend_valid <= reg_wen;      // a write here waits one more cycle
                        pend_waddr <= reg_waddr;
                        pend_wdata <= reg_wdata;
                        arb_state  <= reg_wen ? drac_pkg::DRAIN : drac_pkg::HOST;
                    end
                    default: begin
                        bus_wen   <= reg_wen;       // plain host path
                        bus_waddr <= reg_waddr;
                        bus_wdata <= reg_wdata;
                    end
                endcase
            end
            if (pend_load) begin
                pend_valid <= 1'b1;
                pend_waddr <= reg_waddr;
                pend_wdata <= reg_wdata;
            end
        end
    end

    // only one host write may be outstanding across a block
    a_single_pending: assert property (@(posedge sysclk) disable iff (!rst_n)
        (reg_wen && pend_valid) |-> (arb_state == drac_pkg::DRAIN && !bw_write_en));

endmodule

/* logic/rt_block_writer.sv */
`timescale 1ns/1ps
// maps the k-th quadlet of a real-time block to the setpoint of channel k+1
// quadlets past NUM_MOTORS are dropped; a new blk_wstart restarts the count
module rt_block_writer (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                blk_wstart,
    input  logic                blk_wen,
    input  drac_pkg::reg_data_t reg_wdata,
    output logic                bw_write_en,
    output logic                bw_reg_wen,
    output drac_pkg::reg_addr_t bw_reg_waddr,
    output drac_pkg::reg_data_t bw_reg_wdata
);

    drac_pkg::bw_state_e bw_state;
    drac_pkg::quad_idx_t quad_idx;     // quadlets taken so far
    drac_pkg::quad_idx_t cur_idx;      // index of the quadlet on reg_wdata now
    logic                take;

    assign cur_idx = blk_wstart ? '0 : quad_idx;    // start cycle may carry quadlet 0
    assign take    = blk_wen && (blk_wstart ||
                     (bw_state == drac_pkg::ACTIVE &&
                      quad_idx < drac_pkg::quad_idx_t'(drac_pkg::NUM_MOTORS)));
    assign bw_write_en = (bw_state == drac_pkg::ACTIVE);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            bw_state   <= drac_pkg::IDLE;
            quad_idx   <= '0;
            bw_reg_wen <= 1'b0;
        end else begin
            bw_reg_wen <= take;
            if (take) begin
                quad_idx     <= cur_idx + 1'b1;
                bw_reg_waddr <= drac_pkg::make_addr(drac_pkg::chan_t'(cur_idx + 1'b1),
                                                    drac_pkg::OFS_SETPOINT);
                bw_reg_wdata <= reg_wdata;
            end else if (blk_wstart) begin
                quad_idx <= '0;
            end
            if (blk_wstart) begin
                bw_state <= drac_pkg::ACTIVE;
            end else if (bw_state == drac_pkg::ACTIVE &&
                         quad_idx == drac_pkg::quad_idx_t'(drac_pkg::NUM_MOTORS)) begin
                bw_state <= drac_pkg::IDLE;   // one cycle after the last bw_reg_wen
            end
        end
    end

    // quadlets come inside a block, or as extras after a full one
    a_wen_in_block: assert property (@(posedge sysclk) disable iff (!rst_n)
        blk_wen |-> (blk_wstart || bw_state == drac_pkg::ACTIVE ||
                     quad_idx == drac_pkg::quad_idx_t'(drac_pkg::NUM_MOTORS)));

endmodule

/* logic/motor_regs.sv */
`timescale 1ns/1ps
// per-channel DAC setpoint and amplifier enable, plus the board status read port
// a watchdog timeout drops every enable and blocks enable writes until cleared
module motor_regs (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                bus_wen,
    input  drac_pkg::reg_addr_t bus_waddr,
    input  drac_pkg::reg_data_t bus_wdata,
    input  drac_pkg::reg_addr_t reg_raddr,
    input  drac_pkg::chan_t     board_id,
    input  logic                wdog_timeout,
    output drac_pkg::reg_data_t reg_rdata,
    output drac_pkg::setpoint_t [drac_pkg::NUM_MOTORS-1:0] motor_setpoints,
    output drac_pkg::amp_mask_t amp_enable
);

    drac_pkg::reg_data_t  wdog_period;    // readback copy of the watchdog period
    drac_pkg::chan_t      wr_chan;
    drac_pkg::ofs_t       wr_ofs;
    drac_pkg::chan_t      rd_chan;
    drac_pkg::ofs_t       rd_ofs;
    drac_pkg::motor_idx_t rd_motor;       // channel 1 is entry 0

    assign wr_chan  = drac_pkg::addr_chan(bus_waddr);
    assign wr_ofs   = drac_pkg::addr_ofs(bus_waddr);
    assign rd_chan  = drac_pkg::addr_chan(reg_raddr);
    assign rd_ofs   = drac_pkg::addr_ofs(reg_raddr);
    assign rd_motor = drac_pkg::motor_idx_t'(rd_chan - 1'b1);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            motor_setpoints <= '0;
            amp_enable      <= '0;
            wdog_period     <= '0;   // 0 = watchdog off
        end else begin
            if (bus_wen && wr_chan == drac_pkg::BOARD_CHAN &&
                wr_ofs == drac_pkg::OFS_WDOG_PERIOD) begin
                wdog_period <= bus_wdata;
            end
            for (int m = 0; m < drac_pkg::NUM_MOTORS; m++) begin
                if (bus_wen && wr_chan == drac_pkg::chan_t'(m + 1)) begin
                    if (wr_ofs == drac_pkg::OFS_SETPOINT)
                        motor_setpoints[m] <= bus_wdata[15:0];
                    if (wr_ofs == drac_pkg::OFS_AMP_EN && !wdog_timeout)
                        amp_enable[m] <= bus_wdata[0];
                end
            end
            if (wdog_timeout)
                amp_enable <= '0;    // edge after timeout rises
        end
    end

    // same-cycle read decode
    always_comb begin
        reg_rdata = '0;              // unmapped
        if (rd_chan == drac_pkg::BOARD_CHAN) begin
            case (rd_ofs)
                drac_pkg::OFS_STATUS:
                    reg_rdata = drac_pkg::status_word(board_id, wdog_timeout, amp_enable);
                drac_pkg::OFS_WDOG_PERIOD: reg_rdata = wdog_period;
                default: ;
            endcase
        end else if (rd_chan <= drac_pkg::chan_t'(drac_pkg::NUM_MOTORS)) begin
            case (rd_ofs)
                drac_pkg::OFS_SETPOINT: reg_rdata = {16'h0000, motor_setpoints[rd_motor]};
                drac_pkg::OFS_AMP_EN:   reg_rdata = {31'h0, amp_enable[rd_motor]};
                default: ;
            endcase
        end
    end

endmodule

/* logic/wdog_timer.sv */
`timescale 1ns/1ps
// host-activity watchdog counted in raw sysclk cycles
// a period of 0 disables it
// the timeout holds until wdog_clear or a new period write
module wdog_timer (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                bus_wen,
    input  drac_pkg::reg_addr_t bus_waddr,
    input  drac_pkg::reg_data_t bus_wdata,
    input  logic                wdog_clear,
    output logic                wdog_timeout
);

    drac_pkg::reg_data_t wdog_period;
    drac_pkg::reg_data_t wdog_count;     // cycles since last host activity
    drac_pkg::chan_t     wr_chan;
    logic                period_wr;
    logic                motor_wr;

    assign wr_chan   = drac_pkg::addr_chan(bus_waddr);
    assign period_wr = bus_wen && wr_chan == drac_pkg::BOARD_CHAN &&
                       drac_pkg::addr_ofs(bus_waddr) == drac_pkg::OFS_WDOG_PERIOD;
    assign motor_wr  = bus_wen && wr_chan != drac_pkg::BOARD_CHAN &&
                       wr_chan <= drac_pkg::chan_t'(drac_pkg::NUM_MOTORS);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_period  <= '0;
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (period_wr) begin
            wdog_period  <= bus_wdata;
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (wdog_clear) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (motor_wr) begin
            wdog_count <= '0;            // restarts the count but keeps the timeout
        end else if (wdog_period != '0 && !wdog_timeout) begin
            wdog_count <= wdog_count + 1'b1;
            if (wdog_count + 1'b1 == wdog_period)
                wdog_timeout <= 1'b1;    // P quiet cycles after a restart
        end
    end

    // a raised timeout always belongs to an enabled watchdog
    a_no_timeout_disabled: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_timeout |-> wdog_period != '0);

endmodule

/* logic/sample_buffer.sv */
`timescale 1ns/1ps
// snapshot buffer: q0 timestamp at start, q1 status, then one setpoint per quadlet
// fills one quadlet per cycle; values are taken as they are in that cycle
// readback before the first sample is undefined
module sample_buffer (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  logic                   sample_start,
    input  drac_pkg::sample_addr_t sample_raddr,
    input  drac_pkg::chan_t        board_id,
    input  logic                   wdog_timeout,
    input  drac_pkg::amp_mask_t    amp_enable,
    input  drac_pkg::setpoint_t [drac_pkg::NUM_MOTORS-1:0] motor_setpoints,
    output logic                   sample_busy,
    output drac_pkg::reg_data_t    sample_rdata,
    output drac_pkg::timestamp_t   timestamp
);

    drac_pkg::reg_data_t   sbuf [drac_pkg::NUM_SAMPLE_QUADS];
    drac_pkg::sample_idx_t widx;         // quadlet being filled
    drac_pkg::timestamp_t  start_ts;     // timestamp at the start pulse
    drac_pkg::reg_data_t   quad_val;
    logic                  start_ok;

    assign start_ok = sample_start && !sample_busy;   // start while busy is dropped

    always_comb begin
        if (widx == '0)
            quad_val = start_ts;
        else if (widx == drac_pkg::sample_idx_t'(1))
            quad_val = drac_pkg::status_word(board_id, wdog_timeout, amp_enable);
        else
            quad_val = {16'h0000, motor_setpoints[drac_pkg::motor_idx_t'(widx - 2'd2)]};
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            timestamp   <= '0;
            sample_busy <= 1'b0;
            widx        <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;   // free running
            if (start_ok) begin
                sample_busy <= 1'b1;
                widx        <= '0;
            end else if (sample_busy) begin
                widx <= widx + 1'b1;
                if (widx == drac_pkg::sample_idx_t'(drac_pkg::NUM_SAMPLE_QUADS - 1))
                    sample_busy <= 1'b0;     // NUM_SAMPLE_QUADS busy cycles
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (start_ok)
            start_ts <= timestamp;
        if (sample_busy)
            sbuf[widx] <= quad_val;
    end

    assign sample_rdata =
        (sample_raddr < drac_pkg::sample_addr_t'(drac_pkg::NUM_SAMPLE_QUADS)) ?
        sbuf[drac_pkg::sample_idx_t'(sample_raddr)] : '0;

endmodule

/* logic/drac_top.sv */
`timescale 1ns/1ps
// four-channel motor register side, single sysclk domain
// host writes and real-time blocks share one write bus through the arbiter
module drac_top (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  drac_pkg::reg_addr_t    reg_waddr,
    input  drac_pkg::reg_data_t    reg_wdata,
    input  logic                   reg_wen,
    input  logic                   blk_wstart,
    input  logic                   blk_wen,
    input  drac_pkg::reg_addr_t    reg_raddr,
    output drac_pkg::reg_data_t    reg_rdata,
    input  logic                   sample_start,
    output logic                   sample_busy,
    input  drac_pkg::sample_addr_t sample_raddr,
    output drac_pkg::reg_data_t    sample_rdata,
    input  logic                   wdog_clear,
    input  drac_pkg::chan_t        board_id,
    output logic                   wdog_timeout,
    output drac_pkg::amp_mask_t    amp_enable,
    output drac_pkg::setpoint_t [drac_pkg::NUM_MOTORS-1:0] motor_setpoints
);

    logic                bw_write_en;    // block writer owns the bus
    logic                bw_reg_wen;
    drac_pkg::reg_addr_t bw_reg_waddr;
    drac_pkg::reg_data_t bw_reg_wdata;
    logic                bus_wen;        // shared write bus
    drac_pkg::reg_addr_t bus_waddr;
    drac_pkg::reg_data_t bus_wdata;

    rt_block_writer bw (
        .sysclk(sysclk), .rst_n(rst_n),
        .blk_wstart(blk_wstart), .blk_wen(blk_wen), .reg_wdata(reg_wdata),
        .bw_write_en(bw_write_en), .bw_reg_wen(bw_reg_wen),
        .bw_reg_waddr(bw_reg_waddr), .bw_reg_wdata(bw_reg_wdata)
    );

    write_bus_arbiter arb (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .bw_write_en(bw_write_en), .bw_reg_wen(bw_reg_wen),
        .bw_reg_waddr(bw_reg_waddr), .bw_reg_wdata(bw_reg_wdata),
        .bus_wen(bus_wen), .bus_waddr(bus_waddr), .bus_wdata(bus_wdata)
    );

    motor_regs regs (
        .sysclk(sysclk), .rst_n(rst_n),
        .bus_wen(bus_wen), .bus_waddr(bus_waddr), .bus_wdata(bus_wdata),
        .reg_raddr(reg_raddr), .board_id(board_id), .wdog_timeout(wdog_timeout),
        .reg_rdata(reg_rdata), .motor_setpoints(motor_setpoints),
        .amp_enable(amp_enable)
    );

    wdog_timer wdog (
        .sysclk(sysclk), .rst_n(rst_n),
        .bus_wen(bus_wen), .bus_waddr(bus_waddr), .bus_wdata(bus_wdata),
        .wdog_clear(wdog_clear), .wdog_timeout(wdog_timeout)
    );

    // timestamp stays internal to the sampler
    sample_buffer sampler (
        .sysclk(sysclk), .rst_n(rst_n),
        .sample_start(sample_start), .sample_raddr(sample_raddr),
        .board_id(board_id), .wdog_timeout(wdog_timeout),
        .amp_enable(amp_enable), .motor_setpoints(motor_setpoints),
        .sample_busy(sample_busy), .sample_rdata(sample_rdata),
        .timestamp()
    );

endmodule

/* tests/drac_tb.sv */
`timescale 1ns/1ps
// runs the commands of tests/drac_patterns.txt against drac_top
// setpoint expectations come from a model of the writes driven, the rest from the file
// inputs change on falling edges, outputs are sampled a quarter period later
module drac_tb;

    localparam int PERIOD = 100;

    logic                   sysclk;
    logic                   rst_n;
    drac_pkg::reg_addr_t    reg_waddr;
    drac_pkg::reg_data_t    reg_wdata;
    logic                   reg_wen;
    logic                   blk_wstart;
    logic                   blk_wen;
    drac_pkg::reg_addr_t    reg_raddr;
    drac_pkg::reg_data_t    reg_rdata;
    logic                   sample_start;
    logic                   sample_busy;
    drac_pkg::sample_addr_t sample_raddr;
    drac_pkg::reg_data_t    sample_rdata;
    logic                   wdog_clear;
    drac_pkg::chan_t        board_id;
    logic                   wdog_timeout;
    drac_pkg::amp_mask_t    amp_enable;
    drac_pkg::setpoint_t [drac_pkg::NUM_MOTORS-1:0] motor_setpoints;

    int                   mismatches;
    int                   other_errors;
    int                   num_cmds;
    logic                 loaded;                       // pattern file read in
    string                lines[$];
    drac_pkg::reg_data_t  blk_data [6];                 // quadlets of the current block
    drac_pkg::setpoint_t  model_sp [drac_pkg::NUM_MOTORS];
    drac_pkg::timestamp_t prev_ts;

    drac_top UUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #(PERIOD/2) sysclk = ~sysclk;
    end

    task automatic check_data(input string name, input drac_pkg::reg_data_t got,
                              input drac_pkg::reg_data_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input drac_pkg::amp_mask_t got,
                              input drac_pkg::amp_mask_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // setpoint writes land in the model in the order they were issued
    function automatic void note_write(input drac_pkg::reg_addr_t addr,
                                       input drac_pkg::reg_data_t data);
        int ch;
        ch = int'(addr[7:4]);
        if (ch >= 1 && ch <= drac_pkg::NUM_MOTORS && addr[3:0] == 4'h0)
            model_sp[ch - 1] = data[15:0];
    endfunction

    task automatic host_write(input drac_pkg::reg_addr_t addr, input drac_pkg::reg_data_t data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        note_write(addr, data);
        @(negedge sysclk);
        reg_wen = 1'b0;
        @(negedge sysclk);     // readable two edges after the strobe
    endtask

    task automatic read_check(input drac_pkg::reg_addr_t addr, input drac_pkg::reg_data_t exp);
        reg_raddr = addr;
        #(PERIOD/4);
        check_data($sformatf("reg_rdata[%h]", addr), reg_rdata, exp);
        @(negedge sysclk);
    endtask

    task automatic run_block(input int n, input int hpos, input drac_pkg::reg_addr_t haddr,
                             input drac_pkg::reg_data_t hdata);
        blk_wstart = 1'b1;
        @(negedge sysclk);
        blk_wstart = 1'b0;
        for (int k = 0; k < n; k++) begin
            blk_wen   = 1'b1;
            reg_wdata = blk_data[k];
            if (k < drac_pkg::NUM_MOTORS)
                model_sp[k] = blk_data[k][15:0];    // quadlet k -> channel k+1
            @(negedge sysclk);
            blk_wen = 1'b0;
            if (k == hpos) begin                     // host write in a gap of the block
                reg_waddr = haddr;
                reg_wdata = hdata;
                reg_wen   = 1'b1;
                note_write(haddr, hdata);
                @(negedge sysclk);
                reg_wen = 1'b0;
            end
        end
        repeat (5) @(negedge sysclk);                // end of block, drain, register update
    endtask

    task automatic verify_setpoints();
        for (int m = 0; m < drac_pkg::NUM_MOTORS; m++) begin
            check_data($sformatf("motor_setpoints[%0d]", m), {16'h0000, motor_setpoints[m]},
                       {16'h0000, model_sp[m]});
            read_check({8'h00, drac_pkg::chan_t'(m + 1), 4'h0}, {16'h0000, model_sp[m]});
        end
    endtask

    task automatic sample_read(input int idx, output drac_pkg::reg_data_t q);
        sample_raddr = drac_pkg::sample_addr_t'(idx);
        #(PERIOD/4);
        q = sample_rdata;
        @(negedge sysclk);
    endtask

    task automatic run_sample(input drac_pkg::reg_data_t status);
        int                  busy_cycles;
        drac_pkg::reg_data_t q;
        sample_start = 1'b1;
        @(negedge sysclk);
        sample_start = 1'b0;
        check_bit("sample_busy", sample_busy, 1'b1);
        busy_cycles = 0;
        while (sample_busy && busy_cycles <= 4 * drac_pkg::NUM_SAMPLE_QUADS) begin
            sample_start = (busy_cycles == 1);       // a restart while busy is ignored
            busy_cycles++;
            @(negedge sysclk);
        end
        sample_start = 1'b0;
        if (sample_busy)
            report_failure("sample_busy did not fall after a sample");
        check_data("sample_busy cycles", drac_pkg::reg_data_t'(busy_cycles),
                   drac_pkg::reg_data_t'(drac_pkg::NUM_SAMPLE_QUADS));
        sample_read(0, q);
        if (q <= prev_ts)
            report_failure($sformatf("sample timestamp %0d is not above the previous %0d",
                                     q, prev_ts));
        prev_ts = q;
        sample_read(1, q);
        check_data("sample status", q, status);
        for (int m = 0; m < drac_pkg::NUM_MOTORS; m++) begin
            sample_read(m + 2, q);
            check_data($sformatf("sample setpoint %0d", m + 1), q, {16'h0000, model_sp[m]});
        end
        sample_read(drac_pkg::NUM_SAMPLE_QUADS, q);   // past the end
        check_data("sample_rdata past end", q, '0);
        sample_read(63, q);
        check_data("sample_rdata at 63", q, '0);
    endtask

    initial begin
        int                  fd;
        int                  n;
        int                  rnd;
        int                  hpos;
        string               line;
        string               cmd;
        byte                 c;
        drac_pkg::reg_addr_t a;
        drac_pkg::reg_data_t d;
        drac_pkg::amp_mask_t mk;
        rst_n = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen = 1'b0;
        blk_wstart = 1'b0;
        blk_wen = 1'b0;
        reg_raddr = '0;
        sample_start = 1'b0;
        sample_raddr = '0;
        wdog_clear = 1'b0;
        board_id = 4'ha;
        mismatches = 0;
        other_errors = 0;
        prev_ts = '0;
        loaded = 1'b0;
        void'($urandom(8230));
        fd = $fopen("tests/drac_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open tests/drac_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && $sscanf(line, "%s", cmd) == 1 &&
                    cmd.getc(0) != "#")
                    lines.push_back(line);           // comments and blanks dropped
            end
            $fclose(fd);
        end
        num_cmds = lines.size();
        loaded = 1'b1;
        repeat (4) @(negedge sysclk);
        rst_n = 1'b1;
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s", cmd));
            c = cmd.getc(0);
            case (c)
                "W": begin
                    void'($sscanf(lines[i], "%s %h %h", cmd, a, d));
                    host_write(a, d);
                end
                "R": begin
                    void'($sscanf(lines[i], "%s %h %h", cmd, a, d));
                    read_check(a, d);
                end
                "I": begin
                    void'($sscanf(lines[i], "%s %d %h %h", cmd, n, rnd, mk));
                    repeat (n) @(negedge sysclk);
                    check_bit("wdog_timeout", wdog_timeout, rnd[0]);
                    check_mask("amp_enable", amp_enable, mk);
                end
                "X": begin
                    wdog_clear = 1'b1;
                    @(negedge sysclk);
                    wdog_clear = 1'b0;
                    check_bit("wdog_timeout", wdog_timeout, 1'b0);
                end
                "B": begin
                    void'($sscanf(lines[i], "%s %d %d %h %h %h %h %h %h %h %h %h", cmd, n, rnd,
                                  hpos, a, d, blk_data[0], blk_data[1], blk_data[2],
                                  blk_data[3], blk_data[4], blk_data[5]));
                    if (rnd != 0)
                        foreach (blk_data[k]) blk_data[k] = $urandom;
                    run_block(n, hpos, a, d);
                end
                "V": verify_setpoints();
                "S": begin
                    void'($sscanf(lines[i], "%s %h", cmd, d));
                    run_sample(d);
                end
                default: report_failure($sformatf("unknown pattern command %s", cmd));
            endcase
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // limit grows with the number of commands read
    initial begin
        wait (loaded);
        repeat (num_cmds * 64 + 200) @(posedge sysclk);
        $display("run did not finish within %0d clock cycles", num_cmds * 64 + 200);
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* project.f */
logic/drac_pkg.sv
logic/write_bus_arbiter.sv
logic/rt_block_writer.sv
logic/motor_regs.sv
logic/wdog_timer.sv
logic/sample_buffer.sv
logic/drac_top.sv
tests/drac_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds drac_tb with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module drac_tb -o drac_sim

out=$(./obj_dir/drac_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
else
    exit 1
fi

/* tests/drac_patterns.txt */
# W addr data | R addr expected | I cycles timeout amp_mask | X (wdog_clear) | V (setpoints vs driven)
# B count random host_pos host_addr host_data d0..d5 | S expected_status ; host_pos ff = none
I 2 0 0
R 0000 0000000a
W 0010 00001234
W 0020 abcd5678
W 0011 00000001
W 0031 ffffffff
R 0010 00001234
R 0020 00005678
R 0110 00001234
R 0011 00000001
R 0021 00000000
R 0031 00000001
R 0012 00000000
R 0050 00000000
R 0001 00000000
R 0003 00000000
R 0000 0005000a
I 1 0 5
B 4 0 ff 0000 00000000 11111111 22222222 33333333 44444444 00000000 00000000
V
B 6 0 ff 0000 00000000 0000a001 0000a002 0000a003 0000a004 0000a005 0000a006
V
R 0040 0000a004
B 4 0 01 0020 0000beef 0000b001 0000b002 0000b003 0000b004 00000000 00000000
V
R 0020 0000beef
B 4 0 02 0041 00000001 0000c001 0000c002 0000c003 0000c004 00000000 00000000
V
R 0041 00000001
R 0000 000d000a
B 4 0 03 0010 0000d0d0 0000e001 0000e002 0000e003 0000e004 00000000 00000000
V
R 0010 0000d0d0
B 4 1 ff 0000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
V
S 000d000a
W 0030 00007777
S 000d000a
W 0003 00000010
R 0003 00000010
I 30 1 0
R 0000 0000010a
W 0011 00000001
R 0011 00000000
I 2 1 0
X
W 0011 00000001
W 0021 00000001
R 0000 0003000a
I 2 0 3
W 0003 00000000
R 0003 00000000
I 40 0 3
